//--- pipeline_snapshot.f
verilog/snapshot_pkg.sv
verilog/snapshot_control.sv
verilog/fetch_capture.sv
verilog/stage_capture_bank.sv
verilog/snapshot_readout.sv
verilog/pipeline_snapshot.sv
verif/tb_clock_gen.sv
verif/tb_pipeline_snapshot.sv

//--- Bender.yml
package:
  name: pipeline_snapshot

sources:
  - files:
      - verilog/snapshot_pkg.sv
      - verilog/snapshot_control.sv
      - verilog/fetch_capture.sv
      - verilog/stage_capture_bank.sv
      - verilog/snapshot_readout.sv
      - verilog/pipeline_snapshot.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_pipeline_snapshot.sv

//--- verif/tb_pipeline_snapshot.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_snapshot;

    localparam int          ADDR_WIDTH      = 10;
    localparam int          EDGE_TIMEOUT_NS = 40;
    localparam int          RANDOM_CYCLES   = 400;
    localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;

    logic                      clock;
    logic                      soft_reset;
    logic [3:0]                control;
    logic [ADDR_WIDTH - 1 : 0] cycle_count, pc, next_pc, target_id, target_ex;
    logic                      taken_id, taken_ex;
    logic [31:0]               instruction, data_a, data_b, alu_result, mem_data, wb_alu_data;
    logic [31:0]               o_dato;

    // Reference model of the snapshot and the output register.
    logic [3:0]                m_cmd_q;
    logic [ADDR_WIDTH - 1 : 0] m_cycle, m_pc, m_next_pc, m_target;
    logic                      m_taken;
    logic [31:0]               m_instr, m_data_a, m_data_b, m_alu, m_mem, m_wb, m_dato;

    logic [31:0] lfsr_state;
    logic [31:0] first_reads [0:15];
    int          check_count;
    int          error_count;
    int          test_errors_start;
    int          test_number;

    tb_clock_gen u_clock (.o_clock(clock));

    pipeline_snapshot #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_dut (
        .i_clock            (clock),
        .i_soft_reset       (soft_reset),
        .i_control          (control),
        .i_cycle_count      (cycle_count),
        .i_pc               (pc),
        .i_next_pc          (next_pc),
        .i_branch_target_id (target_id),
        .i_branch_taken_id  (taken_id),
        .i_branch_target_ex (target_ex),
        .i_branch_taken_ex  (taken_ex),
        .i_instruction      (instruction),
        .i_data_a           (data_a),
        .i_data_b           (data_b),
        .i_alu_result       (alu_result),
        .i_mem_data         (mem_data),
        .i_wb_alu_data      (wb_alu_data),
        .o_dato             (o_dato)
    );

    ////////////////////
    // Random numbers.
    ////////////////////
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < count; i++) begin
            out_bit    = lfsr_state[0];
            value      = {value[30:0], out_bit};
            lfsr_state = out_bit ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    function automatic logic [ADDR_WIDTH - 1 : 0] random_addr();
        logic [31:0] value;
        value = random_bits(ADDR_WIDTH);
        return value[ADDR_WIDTH - 1 : 0];
    endfunction

    function automatic logic [3:0] random_command();
        logic [31:0] value;
        value = random_bits(4);
        return value[3:0];
    endfunction

    task automatic randomize_inputs();
        logic [31:0] flags;
        cycle_count = random_addr();
        pc          = random_addr();
        next_pc     = random_addr();
        target_id   = random_addr();
        target_ex   = random_addr();
        flags       = random_bits(2);
        taken_id    = flags[1];
        taken_ex    = flags[0];
        instruction = random_bits(32);
        data_a      = random_bits(32);
        data_b      = random_bits(32);
        alu_result  = random_bits(32);
        mem_data    = random_bits(32);
        wb_alu_data = random_bits(32);
    endtask

    ////////////////////
    // Model.
    ////////////////////
    task automatic reset_snapshot_model();
        {m_cycle, m_pc, m_target, m_taken} = '0;
        m_next_pc = 10'd4; // PC+4 of address zero.
        {m_instr, m_data_a, m_data_b, m_alu, m_mem, m_wb} = '0;
    endtask

    function automatic logic [31:0] expected_word(input logic [3:0] code);
        logic [31:0] word;
        word = '0;
        case (code)
            snapshot_pkg::CMD_READ_PC_CYCLES: begin
                word[16 +: ADDR_WIDTH]   = m_pc;
                word[ADDR_WIDTH - 1 : 0] = m_cycle;
            end
            snapshot_pkg::CMD_READ_NEXT_PC_BRANCH: begin
                word[16 +: ADDR_WIDTH]   = m_next_pc;
                word[15]                 = m_taken;
                word[ADDR_WIDTH - 1 : 0] = m_target;
            end
            snapshot_pkg::CMD_READ_INSTRUCTION: word = m_instr;
            snapshot_pkg::CMD_READ_DATA_A:      word = m_data_a;
            snapshot_pkg::CMD_READ_DATA_B:      word = m_data_b;
            snapshot_pkg::CMD_READ_ALU_RESULT:  word = m_alu;
            snapshot_pkg::CMD_READ_MEM_DATA:    word = m_mem;
            snapshot_pkg::CMD_READ_WB_ALU_DATA: word = m_wb;
            default:                            word = '0; // Unused codes.
        endcase
        return word;
    endfunction

    // Models one rising edge for the registered command and the inputs now driven.
    task automatic model_edge(input logic [3:0] cmd);
        if (m_cmd_q >= 4'd14) begin
            reset_snapshot_model();
            m_dato = '0;
        end
        else if (m_cmd_q == 4'd1) begin
            {m_cycle, m_pc, m_next_pc} = {cycle_count, pc, next_pc};
            m_taken  = taken_id | taken_ex;
            m_target = taken_ex ? target_ex : target_id; // Execute stage has priority.
            {m_instr, m_data_a, m_data_b} = {instruction, data_a, data_b};
            {m_alu, m_mem, m_wb}          = {alu_result, mem_data, wb_alu_data};
            m_dato = '0;
        end
        else if (m_cmd_q != 4'd0) begin
            m_dato = expected_word(m_cmd_q);
        end
        m_cmd_q = cmd;
    endtask

    ////////////////////
    // Checks and sequencing.
    ////////////////////
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic wait_falling_edges(input int count);
        for (int i = 0; i < count; i++) begin
            fork
                @(negedge clock);
                begin
                    #(EDGE_TIMEOUT_NS);
                    $display("Timeout: the clock stopped toggling at %0t", $time);
                    $display("TEST FAILED");
                    $finish;
                end
            join_any
            disable fork;
        end
    endtask

    task automatic next_cycle();
        wait_falling_edges(1);
        check_value("o_dato", o_dato, m_dato);
    endtask

    task automatic issue(input logic [3:0] cmd);
        control = cmd;
        model_edge(cmd);
    endtask

    task automatic step(input logic [3:0] cmd);
        next_cycle();
        randomize_inputs();
        issue(cmd);
    endtask

    // Result lands two edges after the read command.
    task automatic read_expect(input logic [3:0] code, input logic [31:0] expected);
        step(code);
        step(snapshot_pkg::CMD_HOLD);
        next_cycle();
        check_value($sformatf("o_dato after code %0d", code), o_dato, expected);
        randomize_inputs();
        issue(snapshot_pkg::CMD_HOLD);
    endtask

    task automatic branch_case(input logic id_flag, input logic ex_flag);
        logic [ADDR_WIDTH - 1 : 0] exp_target;
        step(snapshot_pkg::CMD_CAPTURE);
        next_cycle();
        randomize_inputs();
        taken_id   = id_flag;
        taken_ex   = ex_flag;
        exp_target = ex_flag ? target_ex : target_id;
        issue(snapshot_pkg::CMD_READ_NEXT_PC_BRANCH);
        step(snapshot_pkg::CMD_HOLD);
        next_cycle();
        check_value("o_dato[15]", {31'b0, o_dato[15]}, {31'b0, id_flag | ex_flag});
        check_value("o_dato[9:0]", {22'b0, o_dato[ADDR_WIDTH - 1 : 0]}, {22'b0, exp_target});
        randomize_inputs();
        issue(snapshot_pkg::CMD_HOLD);
    endtask

    task automatic end_test(input string name);
        test_number++;
        if (error_count == test_errors_start) begin
            $display("Test %0d %s: passed", test_number, name);
        end
        else begin
            $display("Test %0d %s: failed with %0d errors", test_number, name,
                     error_count - test_errors_start);
        end
        test_errors_start = error_count;
    endtask

    initial begin
        logic [31:0] held;
        logic [3:0]  code;
        lfsr_state = 32'd36;
        soft_reset = 1'b0;
        control    = '0;
        {cycle_count, pc, next_pc, target_id, target_ex, taken_id, taken_ex} = '0;
        {instruction, data_a, data_b, alu_result, mem_data, wb_alu_data}    = '0;
        {check_count, error_count, test_errors_start, test_number}          = '0;
        reset_snapshot_model();
        m_dato  = '0;
        m_cmd_q = '0;

        wait_falling_edges(4); // Four rising edges in reset.
        soft_reset = 1'b1;
        check_value("o_dato", o_dato, 32'h0);
        issue(snapshot_pkg::CMD_HOLD);
        read_expect(4'd3, 32'h0004_0000);
        read_expect(4'd2, 32'h0);
        read_expect(4'd4, 32'h0);
        read_expect(4'd13, 32'h0);
        end_test("reset values");

        read_expect(4'd3, 32'h0004_0000); // Nonzero word for the capture to clear.
        step(snapshot_pkg::CMD_CAPTURE);
        step(snapshot_pkg::CMD_HOLD);
        next_cycle();
        check_value("o_dato after capture", o_dato, 32'h0);
        randomize_inputs();
        issue(snapshot_pkg::CMD_HOLD);
        for (code = 4'd2; code <= 4'd13; code++) begin
            read_expect(code, expected_word(code));
        end
        end_test("capture and readout");

        for (int k = 0; k < 12; k++) begin
            branch_case(k[0], k[1]);
        end
        end_test("branch merge");

        step(snapshot_pkg::CMD_CAPTURE);
        step(snapshot_pkg::CMD_HOLD);
        for (code = 4'd2; code <= 4'd13; code++) begin
            first_reads[code] = expected_word(code);
            read_expect(code, first_reads[code]);
        end
        held = first_reads[13];
        repeat (6) begin
            next_cycle();
            check_value("o_dato during hold", o_dato, held);
            randomize_inputs(); // New inputs without a capture.
            issue(snapshot_pkg::CMD_HOLD);
        end
        for (code = 4'd2; code <= 4'd13; code++) begin
            read_expect(code, first_reads[code]);
        end
        end_test("hold");

        read_expect(4'd7, 32'h0);
        read_expect(4'd8, 32'h0);
        read_expect(4'd10, 32'h0);
        read_expect(4'd11, 32'h0);
        read_expect(4'd4, first_reads[4]);
        step(4'd14);
        read_expect(4'd3, 32'h0004_0000);
        read_expect(4'd2, 32'h0);
        read_expect(4'd4, 32'h0);
        step(snapshot_pkg::CMD_CAPTURE);
        step(4'd15);
        read_expect(4'd13, 32'h0);
        read_expect(4'd3, 32'h0004_0000);
        end_test("unused codes and clear");

        // All sixteen codes back to back.
        repeat (RANDOM_CYCLES) begin
            step(random_command());
        end
        repeat (3) begin
            step(snapshot_pkg::CMD_HOLD);
        end
        end_test("random stream");

        $display("Tests: %0d, checks: %0d, errors: %0d", test_number, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock with a 4 ns period.
module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic o_clock
);

    initial begin
        o_clock = 1'b0;
        forever #(HALF_PERIOD_NS) o_clock = ~o_clock;
    end

endmodule

`default_nettype wire

//--- verilog/pipeline_snapshot.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_snapshot #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire                                         i_clock,
    input  wire                                         i_soft_reset,
    input  wire [snapshot_pkg::CMD_WIDTH - 1 : 0]       i_control,
    input  wire [ADDR_WIDTH - 1 : 0]                    i_cycle_count,

    // Fetch and branch resolution.
    input  wire [ADDR_WIDTH - 1 : 0]                    i_pc,
    input  wire [ADDR_WIDTH - 1 : 0]                    i_next_pc,
    input  wire [ADDR_WIDTH - 1 : 0]                    i_branch_target_id,
    input  wire                                         i_branch_taken_id,
    input  wire [ADDR_WIDTH - 1 : 0]                    i_branch_target_ex,
    input  wire                                         i_branch_taken_ex,

    // Decode, execute and write-back data.
    input  wire [snapshot_pkg::WORD_WIDTH - 1 : 0]      i_instruction,
    input  wire [snapshot_pkg::WORD_WIDTH - 1 : 0]      i_data_a,
    input  wire [snapshot_pkg::WORD_WIDTH - 1 : 0]      i_data_b,
    input  wire [snapshot_pkg::WORD_WIDTH - 1 : 0]      i_alu_result,
    input  wire [snapshot_pkg::WORD_WIDTH - 1 : 0]      i_mem_data,
    input  wire [snapshot_pkg::WORD_WIDTH - 1 : 0]      i_wb_alu_data,

    output logic [snapshot_pkg::WORD_WIDTH - 1 : 0]     o_dato
);

    logic                           capture;
    logic                           clear;
    logic                           read;
    snapshot_pkg::read_sel_t        read_sel;

    logic [ADDR_WIDTH - 1 : 0]      snap_cycle_count;
    logic [ADDR_WIDTH - 1 : 0]      snap_pc;
    logic [ADDR_WIDTH - 1 : 0]      snap_next_pc;
    logic [ADDR_WIDTH - 1 : 0]      snap_branch_target;
    logic                           snap_branch_taken;

    snapshot_pkg::decode_payload_t      decode_in;
    snapshot_pkg::decode_payload_t      decode_snap;
    snapshot_pkg::execute_payload_t     execute_in;
    snapshot_pkg::execute_payload_t     execute_snap;
    snapshot_pkg::writeback_payload_t   writeback_in;
    snapshot_pkg::writeback_payload_t   writeback_snap;

    // Field order follows the struct declarations.
    assign decode_in    = {i_instruction, i_data_a, i_data_b};
    assign execute_in   = i_alu_result;
    assign writeback_in = {i_mem_data, i_wb_alu_data};

    ////////////////////
    // Command decode.
    ////////////////////
    snapshot_control u_control (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_control    (i_control),
        .o_capture    (capture),
        .o_clear      (clear),
        .o_read       (read),
        .o_read_sel   (read_sel)
    );

    ////////////////////
    // Capture banks.
    ////////////////////
    fetch_capture #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_fetch (
        .i_clock            (i_clock),
        .i_soft_reset       (i_soft_reset),
        .i_capture          (capture),
        .i_clear            (clear),
        .i_cycle_count      (i_cycle_count),
        .i_pc               (i_pc),
        .i_next_pc          (i_next_pc),
        .i_branch_target_id (i_branch_target_id),
        .i_branch_taken_id  (i_branch_taken_id),
        .i_branch_target_ex (i_branch_target_ex),
        .i_branch_taken_ex  (i_branch_taken_ex),
        .o_cycle_count      (snap_cycle_count),
        .o_pc               (snap_pc),
        .o_next_pc          (snap_next_pc),
        .o_branch_target    (snap_branch_target),
        .o_branch_taken     (snap_branch_taken)
    );

    stage_capture_bank #(
        .payload_t (snapshot_pkg::decode_payload_t)
    ) u_decode_bank (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_capture    (capture),
        .i_clear      (clear),
        .i_payload    (decode_in),
        .o_payload    (decode_snap)
    );

    stage_capture_bank #(
        .payload_t (snapshot_pkg::execute_payload_t)
    ) u_execute_bank (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_capture    (capture),
        .i_clear      (clear),
        .i_payload    (execute_in),
        .o_payload    (execute_snap)
    );

    stage_capture_bank #(
        .payload_t (snapshot_pkg::writeback_payload_t)
    ) u_writeback_bank (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_capture    (capture),
        .i_clear      (clear),
        .i_payload    (writeback_in),
        .o_payload    (writeback_snap)
    );

    ////////////////////
    // Output word.
    ////////////////////
    snapshot_readout #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_readout (
        .i_clock         (i_clock),
        .i_soft_reset    (i_soft_reset),
        .i_capture       (capture),
        .i_clear         (clear),
        .i_read          (read),
        .i_read_sel      (read_sel),
        .i_cycle_count   (snap_cycle_count),
        .i_pc            (snap_pc),
        .i_next_pc       (snap_next_pc),
        .i_branch_target (snap_branch_target),
        .i_branch_taken  (snap_branch_taken),
        .i_decode        (decode_snap),
        .i_execute       (execute_snap),
        .i_writeback     (writeback_snap),
        .o_dato          (o_dato)
    );

endmodule

`default_nettype wire

//--- verilog/snapshot_readout.sv
`timescale 1ns/1ps
`default_nettype none

module snapshot_readout #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire                                         i_clock,
    input  wire                                         i_soft_reset,
    input  wire                                         i_capture,
    input  wire                                         i_clear,
    input  wire                                         i_read,
    input  wire snapshot_pkg::read_sel_t                i_read_sel,
    input  wire [ADDR_WIDTH - 1 : 0]                    i_cycle_count,
    input  wire [ADDR_WIDTH - 1 : 0]                    i_pc,
    input  wire [ADDR_WIDTH - 1 : 0]                    i_next_pc,
    input  wire [ADDR_WIDTH - 1 : 0]                    i_branch_target,
    input  wire                                         i_branch_taken,
    input  wire snapshot_pkg::decode_payload_t          i_decode,
    input  wire snapshot_pkg::execute_payload_t         i_execute,
    input  wire snapshot_pkg::writeback_payload_t       i_writeback,
    output logic [snapshot_pkg::WORD_WIDTH - 1 : 0]     o_dato
);

    localparam int HIGH_FIELD_LSB = 16;
    localparam int TAKEN_BIT      = 15;

    logic [snapshot_pkg::WORD_WIDTH - 1 : 0] word;

    ////////////////////
    // Word formatting.
    ////////////////////
    always_comb begin
        word = '0;
        case (i_read_sel)
            snapshot_pkg::SEL_PC_CYCLES: begin
                word[HIGH_FIELD_LSB +: ADDR_WIDTH] = i_pc;
                word[ADDR_WIDTH - 1 : 0]           = i_cycle_count;
            end
            snapshot_pkg::SEL_NEXT_PC_BRANCH: begin
                word[HIGH_FIELD_LSB +: ADDR_WIDTH] = i_next_pc;
                word[TAKEN_BIT]                    = i_branch_taken;
                word[ADDR_WIDTH - 1 : 0]           = i_branch_target;
            end
            snapshot_pkg::SEL_INSTRUCTION: begin
                word = i_decode.instruction;
            end
            snapshot_pkg::SEL_DATA_A: begin
                word = i_decode.data_a;
            end
            snapshot_pkg::SEL_DATA_B: begin
                word = i_decode.data_b;
            end
            snapshot_pkg::SEL_ALU_RESULT: begin
                word = i_execute.alu_result;
            end
            snapshot_pkg::SEL_MEM_DATA: begin
                word = i_writeback.mem_data;
            end
            snapshot_pkg::SEL_WB_ALU_DATA: begin
                word = i_writeback.wb_alu_data;
            end
            default: begin
                word = '0; // Dropped fields.
            end
        endcase
    end

    // Output register holds between reads.
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset || i_capture || i_clear) begin
            o_dato <= '0;
        end
        else if (i_read) begin
            o_dato <= word;
        end
    end

endmodule

`default_nettype wire

//--- verilog/stage_capture_bank.sv
`timescale 1ns/1ps
`default_nettype none

// Snapshot of one pipeline stage payload.
module stage_capture_bank #(
    parameter type payload_t = logic [31:0]
) (
    input  wire         i_clock,
    input  wire         i_soft_reset,
    input  wire         i_capture,
    input  wire         i_clear,
    input  wire payload_t i_payload,
    output payload_t    o_payload
);

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset || i_clear) begin
            o_payload <= '0;
        end
        else if (i_capture) begin
            o_payload <= i_payload; // Whole stage in one edge.
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_capture.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_capture #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire                         i_clock,
    input  wire                         i_soft_reset,
    input  wire                         i_capture,
    input  wire                         i_clear,
    input  wire [ADDR_WIDTH - 1 : 0]    i_cycle_count,
    input  wire [ADDR_WIDTH - 1 : 0]    i_pc,
    input  wire [ADDR_WIDTH - 1 : 0]    i_next_pc,
    input  wire [ADDR_WIDTH - 1 : 0]    i_branch_target_id,
    input  wire                         i_branch_taken_id,
    input  wire [ADDR_WIDTH - 1 : 0]    i_branch_target_ex,
    input  wire                         i_branch_taken_ex,
    output logic [ADDR_WIDTH - 1 : 0]   o_cycle_count,
    output logic [ADDR_WIDTH - 1 : 0]   o_pc,
    output logic [ADDR_WIDTH - 1 : 0]   o_next_pc,
    output logic [ADDR_WIDTH - 1 : 0]   o_branch_target,
    output logic                        o_branch_taken
);

    localparam logic [ADDR_WIDTH - 1 : 0] NEXT_PC_RESET =
        snapshot_pkg::PC_RESET_NEXT[ADDR_WIDTH - 1 : 0];

    logic [ADDR_WIDTH - 1 : 0] merged_target;
    logic                      merged_taken;

    ////////////////////
    // Branch merge.
    ////////////////////
    // Execute stage resolves later, so it wins over decode.
    assign merged_taken  = i_branch_taken_id | i_branch_taken_ex;
    assign merged_target = i_branch_taken_ex ? i_branch_target_ex : i_branch_target_id;

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset || i_clear) begin
            o_cycle_count   <= '0;
            o_pc            <= '0;
            o_next_pc       <= NEXT_PC_RESET; // PC+4 of address zero.
            o_branch_target <= '0;
            o_branch_taken  <= 1'b0;
        end
        else if (i_capture) begin
            o_cycle_count   <= i_cycle_count;
            o_pc            <= i_pc;
            o_next_pc       <= i_next_pc;
            o_branch_target <= merged_target;
            o_branch_taken  <= merged_taken;
        end
    end

endmodule

`default_nettype wire

//--- verilog/snapshot_control.sv
`timescale 1ns/1ps
`default_nettype none

module snapshot_control (
    input  wire                                     i_clock,
    input  wire                                     i_soft_reset,
    input  wire [snapshot_pkg::CMD_WIDTH - 1 : 0]   i_control,
    output logic                                    o_capture,
    output logic                                    o_clear,
    output logic                                    o_read,
    output snapshot_pkg::read_sel_t                 o_read_sel
);

    logic [snapshot_pkg::CMD_WIDTH - 1 : 0] command_q;

    // Command is sampled on every clock.
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            command_q <= snapshot_pkg::CMD_HOLD;
        end
        else begin
            command_q <= i_control;
        end
    end

    ////////////////////
    // Strobe decode.
    ////////////////////
    always_comb begin
        o_capture  = 1'b0;
        o_clear    = 1'b0;
        o_read     = 1'b0;
        o_read_sel = snapshot_pkg::SEL_NONE;

        if (command_q >= snapshot_pkg::CMD_CLEAR_MIN) begin
            o_clear = 1'b1;
        end
        else begin
            case (command_q)
                snapshot_pkg::CMD_HOLD: begin
                    // Everything keeps its value.
                end
                snapshot_pkg::CMD_CAPTURE: begin
                    o_capture = 1'b1;
                end
                snapshot_pkg::CMD_READ_PC_CYCLES: begin
                    o_read     = 1'b1;
                    o_read_sel = snapshot_pkg::SEL_PC_CYCLES;
                end
                snapshot_pkg::CMD_READ_NEXT_PC_BRANCH: begin
                    o_read     = 1'b1;
                    o_read_sel = snapshot_pkg::SEL_NEXT_PC_BRANCH;
                end
                snapshot_pkg::CMD_READ_INSTRUCTION: begin
                    o_read     = 1'b1;
                    o_read_sel = snapshot_pkg::SEL_INSTRUCTION;
                end
                snapshot_pkg::CMD_READ_DATA_A: begin
                    o_read     = 1'b1;
                    o_read_sel = snapshot_pkg::SEL_DATA_A;
                end
                snapshot_pkg::CMD_READ_DATA_B: begin
                    o_read     = 1'b1;
                    o_read_sel = snapshot_pkg::SEL_DATA_B;
                end
                snapshot_pkg::CMD_READ_ALU_RESULT: begin
                    o_read     = 1'b1;
                    o_read_sel = snapshot_pkg::SEL_ALU_RESULT;
                end
                snapshot_pkg::CMD_READ_MEM_DATA: begin
                    o_read     = 1'b1;
                    o_read_sel = snapshot_pkg::SEL_MEM_DATA;
                end
                snapshot_pkg::CMD_READ_WB_ALU_DATA: begin
                    o_read     = 1'b1;
                    o_read_sel = snapshot_pkg::SEL_WB_ALU_DATA;
                end
                default: begin
                    o_read = 1'b1; // Codes 7, 8, 10, 11 read back zero.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/snapshot_pkg.sv
`default_nettype none

package snapshot_pkg;

    ////////////////////
    // Widths.
    ////////////////////
    localparam int CMD_WIDTH  = 4;
    localparam int WORD_WIDTH = 32;

    ////////////////////
    // Command codes.
    ////////////////////
    localparam logic [CMD_WIDTH - 1 : 0] CMD_HOLD                = 4'd0;
    localparam logic [CMD_WIDTH - 1 : 0] CMD_CAPTURE             = 4'd1;
    localparam logic [CMD_WIDTH - 1 : 0] CMD_READ_PC_CYCLES      = 4'd2;
    localparam logic [CMD_WIDTH - 1 : 0] CMD_READ_NEXT_PC_BRANCH = 4'd3;
    localparam logic [CMD_WIDTH - 1 : 0] CMD_READ_INSTRUCTION    = 4'd4;
    localparam logic [CMD_WIDTH - 1 : 0] CMD_READ_DATA_A         = 4'd5;
    localparam logic [CMD_WIDTH - 1 : 0] CMD_READ_DATA_B         = 4'd6;
    localparam logic [CMD_WIDTH - 1 : 0] CMD_READ_ALU_RESULT     = 4'd9;
    localparam logic [CMD_WIDTH - 1 : 0] CMD_READ_MEM_DATA       = 4'd12;
    localparam logic [CMD_WIDTH - 1 : 0] CMD_READ_WB_ALU_DATA    = 4'd13;
    localparam logic [CMD_WIDTH - 1 : 0] CMD_CLEAR_MIN           = 4'd14; // 14 and up clear.

    // PC+4 snapshot value after reset or clear.
    localparam logic [WORD_WIDTH - 1 : 0] PC_RESET_NEXT = 32'd4;

    // Word chosen by a read command.
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_PC_CYCLES,
        SEL_NEXT_PC_BRANCH,
        SEL_INSTRUCTION,
        SEL_DATA_A,
        SEL_DATA_B,
        SEL_ALU_RESULT,
        SEL_MEM_DATA,
        SEL_WB_ALU_DATA
    } read_sel_t;

    ////////////////////
    // Stage payloads.
    ////////////////////
    typedef struct packed {
        logic [WORD_WIDTH - 1 : 0] instruction;
        logic [WORD_WIDTH - 1 : 0] data_a;
        logic [WORD_WIDTH - 1 : 0] data_b;
    } decode_payload_t;

    typedef struct packed {
        logic [WORD_WIDTH - 1 : 0] alu_result;
    } execute_payload_t;

    typedef struct packed {
        logic [WORD_WIDTH - 1 : 0] mem_data;
        logic [WORD_WIDTH - 1 : 0] wb_alu_data;
    } writeback_payload_t;

endpackage

`default_nettype wire
